// File: logic/dmaBusPkg.sv
// Payload formats seen at the edges of the DMA data path.
// The host side moves whole words and the SCSI side moves halfwords.
package dmaBusPkg;

    // Data width of the host memory bus
    localparam int HOST_WIDTH = 32;

    // Data width of the SCSI data port
    localparam int SCSI_WIDTH = 16;

    // One host bus word
    // The last flag marks the final word of a transfer
    typedef struct packed {
        logic [HOST_WIDTH-1:0] data;
        logic                  last;
    } hostWordT;

    // One SCSI halfword
    // The last flag marks the final halfword of a transfer
    typedef struct packed {
        logic [SCSI_WIDTH-1:0] data;
        logic                  last;
    } scsiHalfT;

endpackage

// File: logic/dmaCtrlPkg.sv
// Control types for the shared word buffer and the transfer direction.
// Buffer entries carry a full host word together with its last flag.
package dmaCtrlPkg;

    import dmaBusPkg::*;

    // Width of the outbound credit counters in both ports
    // Wide enough that a sink can bank credits well ahead of the data
    localparam int CREDIT_W = 16;

    // Which way the data flows through the buffer
    typedef enum logic {
        DIR_TO_SCSI   = 1'b0,
        DIR_FROM_SCSI = 1'b1
    } dirT;

    // One buffer access from a port
    // The payload only matters for a write
    typedef struct packed {
        logic     write;
        hostWordT data;
    } bufReqT;

    // Read data from the buffer, valid one cycle after the read grant
    typedef struct packed {
        logic     valid;
        hostWordT data;
    } bufRspT;

endpackage

// File: logic/creditQueue.sv
`timescale 1ns/1ps

// Small input FIFO in front of a port
// The sender owns QUEUE_DEPTH credits, so a push can never meet a full queue
module creditQueue #(
    parameter type payloadT    = logic,
    parameter int  QUEUE_DEPTH = 4
) (
    input  logic    CLK,
    input  logic    rstN,
    input  logic    inValid,
    input  payloadT inItem,
    output logic    credit,
    input  logic    popReady,
    output logic    outValid,
    output payloadT outItem
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    payloadT            mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wrPtr;
    logic [PTR_W-1:0]   rdPtr;
    logic [CNT_W-1:0]   count;
    logic               pop;

    // The head item is always presented, and it leaves when the port takes it
    assign outValid = (count != '0);
    assign outItem  = mem[rdPtr];
    assign pop      = popReady && outValid;

    always_ff @(posedge CLK) begin
        if (inValid) begin
            mem[wrPtr] <= inItem;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            // Pointers wrap by hand because the depth need not be a power of two
            if (inValid) begin
                wrPtr <= (wrPtr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            count  <= count + CNT_W'(inValid) - CNT_W'(pop);
            // One credit goes back the cycle after each item leaves
            credit <= pop;
        end
    end

    // A push into a full queue means the sender spent a credit it did not hold
    noPushWhenFull: assert property (@(posedge CLK) disable iff (!rstN)
        inValid |-> (count < CNT_W'(QUEUE_DEPTH)))
        else $error("creditQueue push while full, sender broke the credit rule");

endmodule

// File: logic/hostPort.sv
`timescale 1ns/1ps

// Host side of the data path
// Toward SCSI it copies queued host words into the buffer
// From SCSI it drains buffer words to the host, one per sink credit
module hostPort import dmaBusPkg::*, dmaCtrlPkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic     CLK,
    input  logic     rstN,
    input  dirT      dir,
    input  logic     hostInValid,
    input  hostWordT hostIn,
    output logic     hostInCredit,
    output logic     hostOutValid,
    output hostWordT hostOut,
    input  logic     hostOutCredit,
    output bufReqT   bufReq,
    output logic     bufReqValid,
    input  logic     bufGrant,
    input  bufRspT   bufRsp,
    input  logic     bufFull,
    input  logic     bufEmpty
);

    logic                toScsi;
    logic                qValid;
    hostWordT            qItem;
    logic                qPop;
    logic                readReq;
    logic                readPending;
    logic [CREDIT_W-1:0] outCredits;

    assign toScsi = (dir == DIR_TO_SCSI);

    creditQueue #(
        .payloadT    (hostWordT),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) uInQueue (
        .CLK      (CLK),
        .rstN     (rstN),
        .inValid  (hostInValid),
        .inItem   (hostIn),
        .credit   (hostInCredit),
        .popReady (qPop),
        .outValid (qValid),
        .outItem  (qItem)
    );

    // A queued word leaves only on the cycle its buffer write is granted
    assign qPop = toScsi && bufGrant;

    // One read at a time, and only with a sink credit already in hand
    assign readReq = !toScsi && !bufEmpty && !readPending && (outCredits != '0);

    always_comb begin
        bufReq.write = toScsi;
        bufReq.data  = qItem;
        bufReqValid  = toScsi ? (qValid && !bufFull) : readReq;
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            readPending  <= 1'b0;
            hostOutValid <= 1'b0;
            outCredits   <= '0;
        end else begin
            // The read stays open until its word has gone out on the host bus
            if (readReq && bufGrant) begin
                readPending <= 1'b1;
            end else if (hostOutValid) begin
                readPending <= 1'b0;
            end
            hostOutValid <= bufRsp.valid;
            outCredits   <= outCredits + CREDIT_W'(hostOutCredit) - CREDIT_W'(hostOutValid);
        end
    end

    always_ff @(posedge CLK) begin
        if (bufRsp.valid) begin
            hostOut <= bufRsp.data;
        end
    end

endmodule

// File: logic/scsiPort.sv
`timescale 1ns/1ps

// SCSI side of the data path
// From SCSI it pairs halfwords into words, low half first
// Toward SCSI it splits each buffer word into two halfwords
module scsiPort import dmaBusPkg::*, dmaCtrlPkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic     CLK,
    input  logic     rstN,
    input  dirT      dir,
    input  logic     scsiInValid,
    input  scsiHalfT scsiIn,
    output logic     scsiInCredit,
    output logic     scsiOutValid,
    output scsiHalfT scsiOut,
    input  logic     scsiOutCredit,
    output bufReqT   bufReq,
    output logic     bufReqValid,
    input  logic     bufGrant,
    input  bufRspT   bufRsp,
    input  logic     bufFull,
    input  logic     bufEmpty
);

    logic                  fromScsi;
    logic                  qValid;
    scsiHalfT              qItem;
    logic                  qPop;
    logic                  lowHeld;
    logic [SCSI_WIDTH-1:0] lowData;
    logic                  packWrite;
    logic                  readReq;
    logic                  readPending;
    logic                  holdHigh;
    scsiHalfT              highHalf;
    logic                  sendHigh;
    logic [CREDIT_W-1:0]   outCredits;

    assign fromScsi = (dir == DIR_FROM_SCSI);

    creditQueue #(
        .payloadT    (scsiHalfT),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) uInQueue (
        .CLK      (CLK),
        .rstN     (rstN),
        .inValid  (scsiInValid),
        .inItem   (scsiIn),
        .credit   (scsiInCredit),
        .popReady (qPop),
        .outValid (qValid),
        .outItem  (qItem)
    );

    // A word is ready once a high half meets a held low half
    // A low half that ends the transfer is written alone with a zero upper half
    assign packWrite = fromScsi && qValid && (lowHeld || qItem.last);

    // Low halves are parked at once, and words leave the queue on their grant
    assign qPop = fromScsi && (packWrite ? bufGrant : qValid);

    // Credits spent by the half on the wire this cycle are not available again
    assign sendHigh = holdHigh && (outCredits > CREDIT_W'(scsiOutValid));
    assign readReq  = !fromScsi && !bufEmpty && !readPending && !holdHigh &&
                      (outCredits > CREDIT_W'(scsiOutValid));

    always_comb begin
        bufReq.write     = fromScsi;
        bufReq.data.last = qItem.last;
        if (lowHeld) begin
            bufReq.data.data = {qItem.data, lowData};
        end else begin
            bufReq.data.data = {{SCSI_WIDTH{1'b0}}, qItem.data};
        end
        bufReqValid = fromScsi ? (packWrite && !bufFull) : readReq;
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            lowHeld      <= 1'b0;
            readPending  <= 1'b0;
            holdHigh     <= 1'b0;
            scsiOutValid <= 1'b0;
            outCredits   <= '0;
        end else begin
            if (qPop && !packWrite) begin
                lowHeld <= 1'b1;
            end else if (qPop) begin
                lowHeld <= 1'b0;
            end
            if (readReq && bufGrant) begin
                readPending <= 1'b1;
            end else if (bufRsp.valid) begin
                readPending <= 1'b0;
            end
            // The low half goes out the cycle after the response and the high half waits
            if (bufRsp.valid) begin
                holdHigh <= 1'b1;
            end else if (sendHigh) begin
                holdHigh <= 1'b0;
            end
            scsiOutValid <= bufRsp.valid || sendHigh;
            outCredits   <= outCredits + CREDIT_W'(scsiOutCredit) - CREDIT_W'(scsiOutValid);
        end
    end

    always_ff @(posedge CLK) begin
        if (qPop && !packWrite) begin
            lowData <= qItem.data;
        end
        if (bufRsp.valid) begin
            // The last flag rides only on the high half
            scsiOut.data  <= bufRsp.data.data[SCSI_WIDTH-1:0];
            scsiOut.last  <= 1'b0;
            highHalf.data <= bufRsp.data.data[HOST_WIDTH-1:SCSI_WIDTH];
            highHalf.last <= bufRsp.data.last;
        end else if (sendHigh) begin
            scsiOut <= highHalf;
        end
    end

endmodule

// File: logic/bufferArbiter.sv
`timescale 1ns/1ps

// Shares the single buffer access per cycle between the two ports
// Read data comes back a cycle later and is steered to the port that asked
module bufferArbiter import dmaCtrlPkg::*; (
    input  logic   CLK,
    input  logic   rstN,
    input  logic   hostReqValid,
    input  bufReqT hostReq,
    output logic   hostGrant,
    output bufRspT hostRsp,
    input  logic   scsiReqValid,
    input  bufReqT scsiReq,
    output logic   scsiGrant,
    output bufRspT scsiRsp,
    output logic   memReqValid,
    output bufReqT memReq,
    input  bufRspT memRsp
);

    logic prioScsi;
    logic rspToScsi;

    // Under contention the port that was not served last time wins
    assign hostGrant   = hostReqValid && (!scsiReqValid || !prioScsi);
    assign scsiGrant   = scsiReqValid && (!hostReqValid || prioScsi);
    assign memReqValid = hostGrant || scsiGrant;
    assign memReq      = scsiGrant ? scsiReq : hostReq;

    always_comb begin
        hostRsp       = memRsp;
        scsiRsp       = memRsp;
        hostRsp.valid = memRsp.valid && !rspToScsi;
        scsiRsp.valid = memRsp.valid && rspToScsi;
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            prioScsi  <= 1'b0;
            rspToScsi <= 1'b0;
        end else begin
            if (hostGrant) begin
                prioScsi <= 1'b1;
            end else if (scsiGrant) begin
                prioScsi <= 1'b0;
            end
            // Remember the owner of the read so its data finds the right port
            if (memReqValid && !memReq.write) begin
                rspToScsi <= scsiGrant;
            end
        end
    end

    // Read data reaches a port only one cycle after that port's read was granted
    hostRspFollowsGrant: assert property (@(posedge CLK) disable iff (!rstN)
        hostRsp.valid |-> $past(hostGrant && !hostReq.write))
        else $error("bufferArbiter gave read data to the host port without its read");

    scsiRspFollowsGrant: assert property (@(posedge CLK) disable iff (!rstN)
        scsiRsp.valid |-> $past(scsiGrant && !scsiReq.write))
        else $error("bufferArbiter gave read data to the scsi port without its read");

endmodule

// File: logic/wordBuffer.sv
`timescale 1ns/1ps

// Ring buffer of host words shared by both ports
// It takes one read or one write per cycle and reports full and empty
module wordBuffer import dmaBusPkg::*, dmaCtrlPkg::*; #(
    parameter int BUF_DEPTH = 16
) (
    input  logic   CLK,
    input  logic   rstN,
    input  dirT    dir,
    input  logic   reqValid,
    input  bufReqT req,
    output bufRspT rsp,
    output logic   full,
    output logic   empty
);

    localparam int PTR_W = $clog2(BUF_DEPTH);

    hostWordT           mem [BUF_DEPTH];
    logic [PTR_W-1:0]   head;
    logic [PTR_W-1:0]   tail;
    logic [PTR_W:0]     count;
    logic               doWrite;
    logic               doRead;
    logic               rspValid;
    hostWordT           rspWord;

    assign doWrite = reqValid && req.write;
    assign doRead  = reqValid && !req.write;
    assign full    = (count == (PTR_W + 1)'(BUF_DEPTH));
    assign empty   = (count == '0);

    assign rsp.valid = rspValid;
    assign rsp.data  = rspWord;

    // Storage and read data are plain payload
    always_ff @(posedge CLK) begin
        if (doWrite) begin
            mem[tail] <= req.data;
        end
        if (doRead) begin
            rspWord <= mem[head];
        end
    end

    // The power of two depth lets the pointers wrap on their own
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            rspValid <= 1'b0;
        end else begin
            if (doWrite) begin
                tail <= tail + 1'b1;
            end
            if (doRead) begin
                head <= head + 1'b1;
            end
            count    <= count + (PTR_W + 1)'(doWrite) - (PTR_W + 1)'(doRead);
            rspValid <= doRead;
        end
    end

    noWriteWhenFull: assert property (@(posedge CLK) disable iff (!rstN)
        doWrite |-> !full)
        else $error("wordBuffer written while full");

    noReadWhenEmpty: assert property (@(posedge CLK) disable iff (!rstN)
        doRead |-> !empty)
        else $error("wordBuffer read while empty");

    // Turning the direction around with words still stored would mix two transfers
    dirOnlyWhenEmpty: assert property (@(posedge CLK) disable iff (!rstN)
        $changed(dir) |-> $past(empty))
        else $error("dir changed while the buffer held data");

endmodule

// File: logic/scsiDmaDatapath.sv
`timescale 1ns/1ps

// Top of the SCSI DMA data path
// Both ports reach the shared word buffer through the arbiter
module scsiDmaDatapath import dmaBusPkg::*, dmaCtrlPkg::*; #(
    parameter int BUF_DEPTH   = 16,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic     CLK,
    input  logic     rstN,
    input  dirT      dir,
    input  logic     hostInValid,
    input  hostWordT hostIn,
    output logic     hostInCredit,
    input  logic     scsiInValid,
    input  scsiHalfT scsiIn,
    output logic     scsiInCredit,
    output logic     hostOutValid,
    output hostWordT hostOut,
    input  logic     hostOutCredit,
    output logic     scsiOutValid,
    output scsiHalfT scsiOut,
    input  logic     scsiOutCredit
);

    bufReqT hostReq;
    logic   hostReqValid;
    logic   hostGrant;
    bufRspT hostRsp;
    bufReqT scsiReq;
    logic   scsiReqValid;
    logic   scsiGrant;
    bufRspT scsiRsp;
    bufReqT memReq;
    logic   memReqValid;
    bufRspT memRsp;
    logic   bufFull;
    logic   bufEmpty;

    hostPort #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) uHostPort (
        .CLK (CLK), .rstN (rstN), .dir (dir),
        .hostInValid  (hostInValid),  .hostIn  (hostIn),  .hostInCredit  (hostInCredit),
        .hostOutValid (hostOutValid), .hostOut (hostOut), .hostOutCredit (hostOutCredit),
        .bufReq (hostReq), .bufReqValid (hostReqValid), .bufGrant (hostGrant),
        .bufRsp (hostRsp), .bufFull (bufFull), .bufEmpty (bufEmpty)
    );

    scsiPort #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) uScsiPort (
        .CLK (CLK), .rstN (rstN), .dir (dir),
        .scsiInValid  (scsiInValid),  .scsiIn  (scsiIn),  .scsiInCredit  (scsiInCredit),
        .scsiOutValid (scsiOutValid), .scsiOut (scsiOut), .scsiOutCredit (scsiOutCredit),
        .bufReq (scsiReq), .bufReqValid (scsiReqValid), .bufGrant (scsiGrant),
        .bufRsp (scsiRsp), .bufFull (bufFull), .bufEmpty (bufEmpty)
    );

    bufferArbiter uArbiter (
        .CLK (CLK), .rstN (rstN),
        .hostReqValid (hostReqValid), .hostReq (hostReq),
        .hostGrant (hostGrant), .hostRsp (hostRsp),
        .scsiReqValid (scsiReqValid), .scsiReq (scsiReq),
        .scsiGrant (scsiGrant), .scsiRsp (scsiRsp),
        .memReqValid (memReqValid), .memReq (memReq), .memRsp (memRsp)
    );

    wordBuffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) uBuffer (
        .CLK (CLK), .rstN (rstN), .dir (dir),
        .reqValid (memReqValid), .req (memReq), .rsp (memRsp),
        .full (bufFull), .empty (bufEmpty)
    );

endmodule

// File: tests/scsiDmaDatapathTb.sv
`timescale 1ns/1ps

// Testbench for the SCSI DMA data path
// Random senders and credit-giving sinks surround the DUT
// A queue model built from the packing rules predicts every outbound item
module scsiDmaDatapathTb import dmaBusPkg::*, dmaCtrlPkg::*; ();

    localparam int BUF_DEPTH   = 16;
    localparam int QUEUE_DEPTH = 4;
    // A sink never runs more than this many credits ahead of the data it has seen
    localparam int SINK_AHEAD  = 8;

    logic     CLK;
    logic     rstN;
    dirT      dir;
    logic     hostInValid;
    hostWordT hostIn;
    logic     hostInCredit;
    logic     scsiInValid;
    scsiHalfT scsiIn;
    logic     scsiInCredit;
    logic     hostOutValid;
    hostWordT hostOut;
    logic     hostOutCredit;
    logic     scsiOutValid;
    scsiHalfT scsiOut;
    logic     scsiOutCredit;

    integer   seed = 87788;
    hostWordT hostSendQ [$];
    scsiHalfT scsiSendQ [$];
    hostWordT expHostQ [$];
    scsiHalfT expScsiQ [$];
    // Sender credits follow the inbound rule and start full after reset
    int       hostCredits = QUEUE_DEPTH;
    int       scsiCredits = QUEUE_DEPTH;
    // Credits handed to each outbound stream and items seen on it, since reset
    int       hostGiven;
    int       hostSeen;
    int       scsiGiven;
    int       scsiSeen;
    bit       sinkOn = 1'b1;
    int       creditRate = 60;
    int       errors;
    int       testErrStart;
    int       passCount;
    int       failCount;
    int       limitCycles;
    int       lens [8];

    scsiDmaDatapath #(
        .BUF_DEPTH   (BUF_DEPTH),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut (
        .CLK (CLK), .rstN (rstN), .dir (dir),
        .hostInValid  (hostInValid),  .hostIn  (hostIn),  .hostInCredit  (hostInCredit),
        .scsiInValid  (scsiInValid),  .scsiIn  (scsiIn),  .scsiInCredit  (scsiInCredit),
        .hostOutValid (hostOutValid), .hostOut (hostOut), .hostOutCredit (hostOutCredit),
        .scsiOutValid (scsiOutValid), .scsiOut (scsiOut), .scsiOutCredit (scsiOutCredit)
    );

    always #50 CLK = ~CLK;

    function automatic bit rollPercent(int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    function automatic int randomBelow(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic checkValue(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic reportFailure(string msg);
        $display("%0t %s", $time, msg);
        errors++;
    endtask

    // Each host word leaves as its low half, then its high half carrying last
    task automatic loadHostWords(int n);
        hostWordT w;
        scsiHalfT h;
        for (int i = 0; i < n; i++) begin
            w.data = $random(seed);
            w.last = (i == n - 1);
            hostSendQ.push_back(w);
            h.data = w.data[SCSI_WIDTH-1:0];
            h.last = 1'b0;
            expScsiQ.push_back(h);
            h.data = w.data[HOST_WIDTH-1:SCSI_WIDTH];
            h.last = w.last;
            expScsiQ.push_back(h);
        end
    endtask

    // Halves pair up low first, and a lone final low half gets a zero upper half
    task automatic loadScsiHalves(int n);
        scsiHalfT              h;
        hostWordT              w;
        logic [SCSI_WIDTH-1:0] lowData;
        for (int i = 0; i < n; i++) begin
            h.data = $random(seed);
            h.last = (i == n - 1);
            scsiSendQ.push_back(h);
            if (i % 2 == 1) begin
                w.data = {h.data, lowData};
                w.last = h.last;
                expHostQ.push_back(w);
            end else if (h.last) begin
                w.data = {{SCSI_WIDTH{1'b0}}, h.data};
                w.last = 1'b1;
                expHostQ.push_back(w);
            end else begin
                lowData = h.data;
            end
        end
    endtask

    task automatic setDirection(dirT d);
        @(posedge CLK);
        dir <= d;
        @(negedge CLK);
    endtask

    // Wait until every item is out, then expect all inbound credits home again
    task automatic waitDrain();
        while (hostSendQ.size() > 0 || scsiSendQ.size() > 0 ||
               expHostQ.size() > 0 || expScsiQ.size() > 0) begin
            @(negedge CLK);
        end
        repeat (4) @(negedge CLK);
        checkValue("hostSenderCredits", hostCredits, QUEUE_DEPTH);
        checkValue("scsiSenderCredits", scsiCredits, QUEUE_DEPTH);
    endtask

    task automatic endTest(string name);
        if (errors == testErrStart) begin
            $display("test %s: ok", name);
            passCount++;
        end else begin
            $display("test %s: FAILED with %0d errors", name, errors - testErrStart);
            failCount++;
        end
        testErrStart = errors;
    endtask

    // Senders and sinks act on the rising edge
    always @(posedge CLK) begin
        hostInValid   <= 1'b0;
        scsiInValid   <= 1'b0;
        hostOutCredit <= 1'b0;
        scsiOutCredit <= 1'b0;
        if (rstN) begin
            if (hostSendQ.size() > 0 && hostCredits > 0 && rollPercent(70)) begin
                hostInValid <= 1'b1;
                hostIn      <= hostSendQ.pop_front();
                hostCredits--;
            end
            if (scsiSendQ.size() > 0 && scsiCredits > 0 && rollPercent(70)) begin
                scsiInValid <= 1'b1;
                scsiIn      <= scsiSendQ.pop_front();
                scsiCredits--;
            end
            if (sinkOn && hostGiven - hostSeen < SINK_AHEAD && rollPercent(creditRate)) begin
                hostOutCredit <= 1'b1;
                hostGiven++;
            end
            if (sinkOn && scsiGiven - scsiSeen < SINK_AHEAD && rollPercent(creditRate)) begin
                scsiOutCredit <= 1'b1;
                scsiGiven++;
            end
        end
    end

    // Outputs are sampled half a cycle after the edge that set them
    always @(negedge CLK) begin
        if (rstN) begin
            if (hostInCredit) begin
                hostCredits++;
                if (hostCredits > QUEUE_DEPTH) begin
                    reportFailure("host sender got back more credits than it spent");
                end
            end
            if (scsiInCredit) begin
                scsiCredits++;
                if (scsiCredits > QUEUE_DEPTH) begin
                    reportFailure("scsi sender got back more credits than it spent");
                end
            end
            if (hostOutValid) begin
                hostSeen++;
                if (hostSeen > hostGiven) begin
                    reportFailure("host out sent a word without holding a credit");
                end
                if (expHostQ.size() == 0) begin
                    reportFailure("host out sent a word that was never expected");
                end else begin
                    checkValue("hostOut", hostOut, expHostQ.pop_front());
                end
            end
            if (scsiOutValid) begin
                scsiSeen++;
                if (scsiSeen > scsiGiven) begin
                    reportFailure("scsi out sent a halfword without holding a credit");
                end
                if (expScsiQ.size() == 0) begin
                    reportFailure("scsi out sent a halfword that was never expected");
                end else begin
                    checkValue("scsiOut", scsiOut, expScsiQ.pop_front());
                end
            end
        end
    end

    // The run limit scales with the number of items in all tests
    initial begin
        wait (limitCycles > 0);
        repeat (limitCycles) @(posedge CLK);
        $display("timeout after %0d cycles with %0d words and %0d halfwords still expected",
                 limitCycles, expHostQ.size(), expScsiQ.size());
        $display("tests failed");
        $finish;
    end

    initial begin
        CLK           = 1'b0;
        rstN          = 1'b0;
        dir           = DIR_TO_SCSI;
        hostInValid   = 1'b0;
        hostIn        = '0;
        scsiInValid   = 1'b0;
        scsiIn        = '0;
        hostOutCredit = 1'b0;
        scsiOutCredit = 1'b0;
        lens[0] = 6 + randomBelow(12);
        lens[1] = 2 * (4 + randomBelow(10));
        lens[2] = 2 * (4 + randomBelow(10)) + 1;
        lens[3] = 6 + randomBelow(12);
        lens[4] = BUF_DEPTH + 2 * QUEUE_DEPTH + 6;
        lens[5] = 6 + randomBelow(12);
        lens[6] = 2 * (3 + randomBelow(10)) + 1;
        lens[7] = 6 + randomBelow(12);
        limitCycles = 0;
        for (int i = 0; i < 8; i++) begin
            limitCycles += lens[i];
        end
        // Tests 3 and 4 send their length once in each direction
        limitCycles = (limitCycles + lens[3] + lens[7]) * 40;
        repeat (8) @(posedge CLK);
        rstN <= 1'b1;

        setDirection(DIR_TO_SCSI);
        loadHostWords(lens[0]);
        waitDrain();
        endTest("1 host to scsi");

        setDirection(DIR_FROM_SCSI);
        loadScsiHalves(lens[1]);
        waitDrain();
        loadScsiHalves(lens[2]);
        waitDrain();
        endTest("2 scsi to host even and odd");

        // Sparse sink credits keep both outbound counters near zero
        creditRate = 20;
        loadScsiHalves(lens[3]);
        waitDrain();
        setDirection(DIR_TO_SCSI);
        loadHostWords(lens[3]);
        waitDrain();
        creditRate = 60;
        endTest("3 outbound credit discipline");

        // Each sender must hold all its credits again once its stream drains
        loadHostWords(lens[7]);
        waitDrain();
        setDirection(DIR_FROM_SCSI);
        loadScsiHalves(lens[7]);
        waitDrain();
        setDirection(DIR_TO_SCSI);
        endTest("4 inbound credit return");

        // With the sink stalled the buffer and input queue fill and the rest waits
        sinkOn = 1'b0;
        loadHostWords(lens[4]);
        repeat (100) @(negedge CLK);
        checkValue("hostSenderCredits", hostCredits, 0);
        if (hostSendQ.size() == 0) begin
            reportFailure("host sender emptied its queue although the sink was stalled");
        end
        sinkOn = 1'b1;
        waitDrain();
        endTest("5 full buffer");

        loadHostWords(lens[5]);
        waitDrain();
        setDirection(DIR_FROM_SCSI);
        loadScsiHalves(lens[6]);
        waitDrain();
        endTest("6 direction change");

        $display("summary: %0d passed, %0d failed, %0d errors", passCount, failCount, errors);
        if (failCount == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: scsiDmaDatapath.f
logic/dmaBusPkg.sv
logic/dmaCtrlPkg.sv
logic/creditQueue.sv
logic/hostPort.sv
logic/scsiPort.sv
logic/bufferArbiter.sv
logic/wordBuffer.sv
logic/scsiDmaDatapath.sv
tests/scsiDmaDatapathTb.sv

// File: Bender.yml
package:
  name: scsiDmaDatapath

sources:
  - files:
      - logic/dmaBusPkg.sv
      - logic/dmaCtrlPkg.sv
      - logic/creditQueue.sv
      - logic/hostPort.sv
      - logic/scsiPort.sv
      - logic/bufferArbiter.sv
      - logic/wordBuffer.sv
      - logic/scsiDmaDatapath.sv

  - target: test
    files:
      - tests/scsiDmaDatapathTb.sv
